// File: hw/decode_front.sv
`default_nettype none

module decode_front import isa_pkg::*; (
	input  logic      pclk,
	input  logic      rst_n,
	// Upstream instruction stream
	input  logic      inst_valid,
	input  inst_t     inst,
	output logic      inst_credit,
	// Writeback
	input  logic      wb_valid,
	input  reg_addr_t wb_addr,
	input  reg_data_t wb_data,
	// To execute
	output logic      op_valid,
	output reg_addr_t read_addr1,
	output reg_addr_t read_addr2,
	output reg_data_t read_data1,
	output reg_data_t read_data2,
	output logic      mem_read,
	output logic      mem_write,
	output logic      reg_write,
	output reg_addr_t reg_addr,
	input  logic      out_credit
);

	logic      q_valid;
	inst_t     q_inst;
	logic      dec_stall;
	logic      dec_valid;
	logic      fetch_stall;
	reg_addr_t dec_read_addr1;
	reg_addr_t dec_read_addr2;
	logic      dec_mem_read;
	logic      dec_mem_write;
	logic      dec_reg_write;
	reg_addr_t dec_reg_addr;

	inst_queue u_queue (
		.pclk        (pclk),
		.rst_n       (rst_n),
		.inst_valid  (inst_valid),
		.inst        (inst),
		.inst_credit (inst_credit),
		.q_valid     (q_valid),
		.q_inst      (q_inst),
		.dec_stall   (dec_stall)
	);

	inst_decoder u_decoder (
		.pclk        (pclk),
		.rst_n       (rst_n),
		.q_valid     (q_valid),
		.q_inst      (q_inst),
		.dec_stall   (dec_stall),
		.fetch_stall (fetch_stall),
		.dec_valid   (dec_valid),
		.read_addr1  (dec_read_addr1),
		.read_addr2  (dec_read_addr2),
		.mem_read    (dec_mem_read),
		.mem_write   (dec_mem_write),
		.reg_write   (dec_reg_write),
		.reg_addr    (dec_reg_addr)
	);

	operand_fetch u_fetch (
		.pclk           (pclk),
		.rst_n          (rst_n),
		.dec_valid      (dec_valid),
		.dec_read_addr1 (dec_read_addr1),
		.dec_read_addr2 (dec_read_addr2),
		.dec_mem_read   (dec_mem_read),
		.dec_mem_write  (dec_mem_write),
		.dec_reg_write  (dec_reg_write),
		.dec_reg_addr   (dec_reg_addr),
		.fetch_stall    (fetch_stall),
		.wb_valid       (wb_valid),
		.wb_addr        (wb_addr),
		.wb_data        (wb_data),
		.out_credit     (out_credit),
		.op_valid       (op_valid),
		.read_addr1     (read_addr1),
		.read_addr2     (read_addr2),
		.read_data1     (read_data1),
		.read_data2     (read_data2),
		.mem_read       (mem_read),
		.mem_write      (mem_write),
		.reg_write      (reg_write),
		.reg_addr       (reg_addr)
	);

endmodule

`default_nettype wire

// File: hw/inst_decoder.sv
`default_nettype none

module inst_decoder import isa_pkg::*; (
	input  logic      pclk,
	input  logic      rst_n,
	input  logic      q_valid,
	input  inst_t     q_inst,
	output logic      dec_stall,
	input  logic      fetch_stall,
	output logic      dec_valid,
	output reg_addr_t read_addr1,
	output reg_addr_t read_addr2,
	output logic      mem_read,
	output logic      mem_write,
	output logic      reg_write,
	output reg_addr_t reg_addr
);

	logic [4:0] opcode;
	reg_addr_t  rx;
	reg_addr_t  ry;
	reg_addr_t  rz;
	reg_addr_t  nxt_addr1;
	reg_addr_t  nxt_addr2;
	logic       nxt_mrd;
	logic       nxt_mwr;
	logic       nxt_wen;
	reg_addr_t  nxt_waddr;

	assign opcode = q_inst[15:11];
	assign rx     = {1'b0, q_inst[10:8]};
	assign ry     = {1'b0, q_inst[7:5]};
	assign rz     = {1'b0, q_inst[4:2]};

	////////////////////////////////////////////////////////////////////////////
	// Decode table
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		nxt_addr1 = '0; // Anything unmatched stays all zero
		nxt_addr2 = '0;
		nxt_mrd   = 1'b0;
		nxt_mwr   = 1'b0;
		nxt_wen   = 1'b0;
		nxt_waddr = '0;
		case (opcode)
			OP_ADDIU: begin
				nxt_addr1 = rx;
				nxt_wen   = 1'b1;
				nxt_waddr = rx;
			end
			OP_ADDIU3: begin
				nxt_addr1 = rx;
				nxt_wen   = 1'b1;
				nxt_waddr = ry;
			end
			OP_SPEC: begin
				if (q_inst[10:8] == 3'b011) begin // ADDSP
					nxt_addr1 = REG_SP;
					nxt_wen   = 1'b1;
					nxt_waddr = REG_SP;
				end else if (q_inst[10:8] == 3'b000) begin // BTEQZ
					nxt_addr1 = REG_T;
				end else if (q_inst[10:8] == 3'b100 && q_inst[4:0] == 5'b00000) begin // MTSP
					nxt_addr1 = ry;
					nxt_wen   = 1'b1;
					nxt_waddr = REG_SP;
				end
			end
			OP_ALU3: begin // ADDU or SUBU, same fields either way
				nxt_addr1 = rx;
				nxt_addr2 = ry;
				nxt_wen   = 1'b1;
				nxt_waddr = rz;
			end
			OP_RR: begin
				if (q_inst[4:0] == 5'b01100 || q_inst[4:0] == 5'b01101) begin // AND, OR
					nxt_addr1 = rx;
					nxt_addr2 = ry;
					nxt_wen   = 1'b1;
					nxt_waddr = rx;
				end else if (q_inst[7:0] == 8'b00000000) begin // JR
					nxt_addr1 = rx;
				end else if (q_inst[4:0] == 5'b01010) begin // CMP
					nxt_addr1 = rx;
					nxt_addr2 = ry;
					nxt_wen   = 1'b1;
					nxt_waddr = REG_T;
				end else if (q_inst[7:0] == 8'b01000000) begin // MFPC
					nxt_wen   = 1'b1;
					nxt_waddr = rx;
				end else if (q_inst[7:0] == 8'b11000000) begin // JALR
					nxt_addr1 = rx;
				end else if (q_inst[10:0] == 11'b00000100000) begin // JRRA
					nxt_addr1 = REG_RA;
				end else if (q_inst[4:0] == 5'b00111) begin // SRAV
					nxt_addr1 = rx;
					nxt_addr2 = ry;
					nxt_wen   = 1'b1;
					nxt_waddr = ry;
				end
			end
			OP_BEQZ, OP_BNEZ: nxt_addr1 = rx;
			OP_LI: begin
				nxt_wen   = 1'b1;
				nxt_waddr = rx;
			end
			OP_LW: begin
				nxt_addr1 = rx;
				nxt_mrd   = 1'b1;
				nxt_wen   = 1'b1;
				nxt_waddr = ry;
			end
			OP_LW_SP: begin
				nxt_addr1 = REG_SP;
				nxt_mrd   = 1'b1;
				nxt_wen   = 1'b1;
				nxt_waddr = rx;
			end
			OP_IH: begin
				if (q_inst[7:0] == 8'b00000000) begin // MFIH into rx
					nxt_addr1 = REG_IH;
					nxt_wen   = 1'b1;
					nxt_waddr = rx;
				end else if (q_inst[4:0] == 5'b00001) begin // MTIH
					nxt_addr1 = rx;
					nxt_wen   = 1'b1;
					nxt_waddr = REG_IH;
				end
			end
			OP_SHIFT, OP_MOVE: begin
				// Shifts use bits 1:0 except 01, MOVE needs bits 4:0 clear
				if ((opcode == OP_SHIFT && q_inst[1:0] != 2'b01) ||
				    (opcode == OP_MOVE && q_inst[4:0] == 5'b00000)) begin
					nxt_addr2 = ry;
					nxt_wen   = 1'b1;
					nxt_waddr = rx;
				end
			end
			OP_SW: begin
				nxt_addr1 = rx;
				nxt_addr2 = ry;
				nxt_mwr   = 1'b1;
			end
			OP_SW_SP: begin
				nxt_addr1 = rx;
				nxt_mwr   = 1'b1;
			end
			default: ; // B and NOP read and write nothing
		endcase
	end

	assign dec_stall = dec_valid && fetch_stall; // Hold only a live operation

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			dec_valid <= 1'b0;
		end else if (!dec_stall) begin
			dec_valid <= q_valid;
		end
	end

	always_ff @(posedge pclk) begin
		if (!dec_stall) begin
			read_addr1 <= nxt_addr1;
			read_addr2 <= nxt_addr2;
			mem_read   <= nxt_mrd;
			mem_write  <= nxt_mwr;
			reg_write  <= nxt_wen;
			reg_addr   <= nxt_waddr;
		end
	end

endmodule

`default_nettype wire

// File: hw/inst_queue.sv
`default_nettype none

module inst_queue import isa_pkg::*, pipe_pkg::*; (
	input  logic  pclk,
	input  logic  rst_n,
	input  logic  inst_valid,
	input  inst_t inst,
	output logic  inst_credit,
	output logic  q_valid,
	output inst_t q_inst,
	input  logic  dec_stall
);

	inst_t   mem [QUEUE_DEPTH];
	q_ptr_t  wr_ptr;
	q_ptr_t  rd_ptr;
	credit_t count;          // Occupancy
	logic    push;
	logic    pop;

	assign push    = inst_valid;             // Upstream only sends with a credit
	assign pop     = q_valid && !dec_stall;
	assign q_valid = (count != '0);
	assign q_inst  = mem[rd_ptr];

	always_ff @(posedge pclk) begin
		if (push) begin
			mem[wr_ptr] <= inst;
		end
	end

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			inst_credit <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1; // Wraps at the depth
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count       <= count + credit_t'(push) - credit_t'(pop);
			inst_credit <= pop; // One credit back per pop
		end
	end

	// Upstream must never push beyond the credits it was given
	assert property (@(posedge pclk) disable iff (!rst_n)
		inst_valid |-> (count != credit_t'(QUEUE_DEPTH)))
		else $error("instruction pushed into a full queue");

endmodule

`default_nettype wire

// File: hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

	typedef logic [15:0] inst_t;     // Instruction word
	typedef logic [3:0]  reg_addr_t; // R0-R7 plus specials
	typedef logic [15:0] reg_data_t;

	//////////////////////////////////////////////////////////////////////////
	// Major opcodes, bits 15:11
	//////////////////////////////////////////////////////////////////////////
	localparam logic [4:0] OP_ADDIU  = 5'b01001;
	localparam logic [4:0] OP_ADDIU3 = 5'b01000;
	localparam logic [4:0] OP_SPEC   = 5'b01100; // ADDSP, BTEQZ, MTSP
	localparam logic [4:0] OP_ALU3   = 5'b11100; // ADDU, SUBU
	localparam logic [4:0] OP_RR     = 5'b11101; // Register-register group
	localparam logic [4:0] OP_B      = 5'b00010;
	localparam logic [4:0] OP_BEQZ   = 5'b00100;
	localparam logic [4:0] OP_BNEZ   = 5'b00101;
	localparam logic [4:0] OP_LI     = 5'b01101;
	localparam logic [4:0] OP_LW     = 5'b10011;
	localparam logic [4:0] OP_LW_SP  = 5'b10010;
	localparam logic [4:0] OP_IH     = 5'b11110; // MFIH, MTIH
	localparam logic [4:0] OP_NOP    = 5'b00001;
	localparam logic [4:0] OP_SHIFT  = 5'b00110; // SLL, SRA, SRL
	localparam logic [4:0] OP_SW     = 5'b11011;
	localparam logic [4:0] OP_SW_SP  = 5'b11010;
	localparam logic [4:0] OP_MOVE   = 5'b01111;

	// Special registers above the eight general ones
	localparam reg_addr_t REG_SP = 4'd8;
	localparam reg_addr_t REG_T  = 4'd9;
	localparam reg_addr_t REG_IH = 4'd10;
	localparam reg_addr_t REG_RA = 4'd11;

	localparam int NUM_REGS = 16;

endpackage

`default_nettype wire

// File: hw/operand_fetch.sv
`default_nettype none

module operand_fetch import isa_pkg::*, pipe_pkg::*; (
	input  logic      pclk,
	input  logic      rst_n,
	input  logic      dec_valid,
	input  reg_addr_t dec_read_addr1,
	input  reg_addr_t dec_read_addr2,
	input  logic      dec_mem_read,
	input  logic      dec_mem_write,
	input  logic      dec_reg_write,
	input  reg_addr_t dec_reg_addr,
	output logic      fetch_stall,
	input  logic      wb_valid,
	input  reg_addr_t wb_addr,
	input  reg_data_t wb_data,
	input  logic      out_credit,
	output logic      op_valid,
	output reg_addr_t read_addr1,
	output reg_addr_t read_addr2,
	output reg_data_t read_data1,
	output reg_data_t read_data2,
	output logic      mem_read,
	output logic      mem_write,
	output logic      reg_write,
	output reg_addr_t reg_addr
);

	reg_data_t rf [NUM_REGS];
	credit_t   credits;  // Free slots downstream
	logic      op_full;  // Operand register holds an operation
	logic      load;

	assign op_valid    = op_full && (credits != '0);
	assign fetch_stall = op_full && (credits == '0);
	assign load        = !fetch_stall; // Empty, or sending this cycle

	////////////////////////////////////////////////////////////////////////////
	// Register file, one write port
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				rf[i] <= '0;
			end
		end else if (wb_valid) begin
			rf[wb_addr] <= wb_data;
		end
	end

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			op_full <= 1'b0;
			credits <= credit_t'(OUT_CREDITS);
		end else begin
			if (load) begin
				op_full <= dec_valid;
			end
			credits <= credits + credit_t'(out_credit) - credit_t'(op_valid);
		end
	end

	// Read ports sample the old value, a same-cycle write lands afterwards
	always_ff @(posedge pclk) begin
		if (load && dec_valid) begin
			read_addr1 <= dec_read_addr1;
			read_addr2 <= dec_read_addr2;
			read_data1 <= rf[dec_read_addr1];
			read_data2 <= rf[dec_read_addr2];
			mem_read   <= dec_mem_read;
			mem_write  <= dec_mem_write;
			reg_write  <= dec_reg_write;
			reg_addr   <= dec_reg_addr;
		end
	end

	// Downstream returns at most what it was given
	assert property (@(posedge pclk) disable iff (!rst_n)
		credits <= credit_t'(OUT_CREDITS))
		else $error("downstream credit count above its limit");

	// Decode stage keeps its operation until this stage takes it
	assert property (@(posedge pclk) disable iff (!rst_n)
		(dec_valid && fetch_stall) |=> (dec_valid && $stable({dec_read_addr1,
			dec_read_addr2, dec_mem_read, dec_mem_write, dec_reg_write, dec_reg_addr})))
		else $error("decoded operation changed while stalled");

endmodule

`default_nettype wire

// File: hw/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	// Queue depth, also the credits upstream holds after reset
	localparam int QUEUE_DEPTH = 4;

	// Operations the execute unit can take
	localparam int OUT_CREDITS = 2;

	typedef logic [$clog2(QUEUE_DEPTH)-1:0]   q_ptr_t;
	typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] credit_t; // 0 to QUEUE_DEPTH

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the decode front end testbench with Verilator

verilator --binary --timing --assert -f verilog.f --top-module tb_decode_front \
	-o sim_decode_front
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_decode_front)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
	exit 0
fi
exit 1

// File: testbench/decode_checker.sv
`default_nettype none

module decode_checker import isa_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      inst_valid,
	input  inst_t     inst,
	input  logic      wb_valid,
	input  reg_addr_t wb_addr,
	input  reg_data_t wb_data,
	input  logic      op_valid,
	input  reg_addr_t read_addr1,
	input  reg_addr_t read_addr2,
	input  reg_data_t read_data1,
	input  reg_data_t read_data2,
	input  logic      mem_read,
	input  logic      mem_write,
	input  logic      reg_write,
	input  reg_addr_t reg_addr,
	output int        err_count,
	output int        op_count,
	output int        pending
);

	timeunit 1ns;
	timeprecision 1ps;

	inst_t     exp_q [$];       // Accepted, not yet seen at the output
	reg_data_t mirror [NUM_REGS];

	// Expected {addr1, addr2, mem_read, mem_write, reg_write, reg_addr}
	function automatic logic [14:0] ref_decode(input inst_t w);
		reg_addr_t rx;
		reg_addr_t ry;
		reg_addr_t rz;
		reg_addr_t a1;
		reg_addr_t a2;
		reg_addr_t wa;
		logic      mrd;
		logic      mwr;
		logic      wen;
		rx  = {1'b0, w[10:8]};
		ry  = {1'b0, w[7:5]};
		rz  = {1'b0, w[4:2]};
		a1  = '0;
		a2  = '0;
		wa  = '0;
		mrd = 1'b0;
		mwr = 1'b0;
		wen = 1'b0;
		case (w[15:11])
			OP_ADDIU: begin
				a1  = rx;
				wen = 1'b1;
				wa  = rx;
			end
			OP_ADDIU3: begin
				a1  = rx;
				wen = 1'b1;
				wa  = ry;
			end
			OP_SPEC: begin
				if (w[10:8] == 3'b011) begin
					a1  = REG_SP;
					wen = 1'b1;
					wa  = REG_SP;
				end
				if (w[10:8] == 3'b000) a1 = REG_T;
				if (w[10:8] == 3'b100 && w[4:0] == 5'd0) begin
					a1  = ry;
					wen = 1'b1;
					wa  = REG_SP;
				end
			end
			OP_ALU3: begin
				a1  = rx;
				a2  = ry;
				wen = 1'b1;
				wa  = rz;
			end
			OP_RR: begin
				if (w[4:0] == 5'b01100 || w[4:0] == 5'b01101) begin // AND, OR
					a1  = rx;
					a2  = ry;
					wen = 1'b1;
					wa  = rx;
				end else if (w[7:0] == 8'h00 || w[7:0] == 8'hc0) begin
					a1 = rx;                                 // JR, JALR
				end else if (w[4:0] == 5'b01010) begin       // CMP
					a1  = rx;
					a2  = ry;
					wen = 1'b1;
					wa  = REG_T;
				end else if (w[7:0] == 8'h40) begin          // MFPC
					wen = 1'b1;
					wa  = rx;
				end else if (w[10:0] == 11'h020) begin
					a1 = REG_RA;                             // JRRA
				end else if (w[4:0] == 5'b00111) begin       // SRAV
					a1  = rx;
					a2  = ry;
					wen = 1'b1;
					wa  = ry;
				end
			end
			OP_BEQZ, OP_BNEZ: a1 = rx;
			OP_LI: begin
				wen = 1'b1;
				wa  = rx;
			end
			OP_LW: begin
				a1  = rx;
				mrd = 1'b1;
				wen = 1'b1;
				wa  = ry;
			end
			OP_LW_SP: begin
				a1  = REG_SP;
				mrd = 1'b1;
				wen = 1'b1;
				wa  = rx;
			end
			OP_IH: begin
				if (w[7:0] == 8'h00) begin
					a1  = REG_IH;
					wen = 1'b1;
					wa  = rx;
				end else if (w[4:0] == 5'b00001) begin
					a1  = rx;
					wen = 1'b1;
					wa  = REG_IH;
				end
			end
			OP_SHIFT: begin
				if (w[1:0] != 2'b01) begin
					a2  = ry;
					wen = 1'b1;
					wa  = rx;
				end
			end
			OP_MOVE: begin
				if (w[4:0] == 5'd0) begin
					a2  = ry;
					wen = 1'b1;
					wa  = rx;
				end
			end
			OP_SW: begin
				a1  = rx;
				a2  = ry;
				mwr = 1'b1;
			end
			OP_SW_SP: begin
				a1  = rx;
				mwr = 1'b1;
			end
			default: ;
		endcase
		return {a1, a2, mrd, mwr, wen, wa};
	endfunction

	//////////////////////////////////////////////////////////////////////////
	// Sampled mid-cycle, away from both the DUT edge and the drive delay
	//////////////////////////////////////////////////////////////////////////
	always @(negedge clk) begin
		logic [14:0] e;
		logic [14:0] got;
		inst_t       w;
		if (!rst_n) begin
			exp_q.delete();
			for (int i = 0; i < NUM_REGS; i++) mirror[i] = '0;
		end else begin
			if (op_valid) begin
				op_count++;
				if (exp_q.size() == 0) begin
					err_count++;
					$display("[ERROR] %0t op_valid with no instruction outstanding", $time);
				end else begin
					w   = exp_q.pop_front();
					e   = ref_decode(w);
					got = {read_addr1, read_addr2, mem_read, mem_write, reg_write, reg_addr};
					if (got !== e || read_data1 !== mirror[e[14:11]] ||
					    read_data2 !== mirror[e[10:7]]) begin
						err_count++;
						$display("[ERROR] %0t inst %h: fields %h data %h/%h, expected %h data %h/%h",
							$time, w, got, read_data1, read_data2, e,
							mirror[e[14:11]], mirror[e[10:7]]);
					end
				end
			end
			if (wb_valid) mirror[wb_addr] = wb_data;
			if (inst_valid) exp_q.push_back(inst);
		end
		pending = exp_q.size();
	end

	initial begin
		err_count = 0;
		op_count  = 0;
		pending   = 0;
	end

endmodule

`default_nettype wire

// File: testbench/tb_decode_front.sv
`default_nettype none

module tb_decode_front import isa_pkg::*, pipe_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] SEED  = 32'h999990e2;
	localparam int          TEST_LEN    = 341; // Directed, illegal, stall and random
	localparam int          CYCLE_LIMIT = 40 * TEST_LEN + 200;

	logic      clk;
	logic      rst_n;
	logic      inst_valid;
	inst_t     inst;
	logic      inst_credit;
	logic      wb_valid;
	reg_addr_t wb_addr;
	reg_data_t wb_data;
	logic      op_valid;
	reg_addr_t read_addr1;
	reg_addr_t read_addr2;
	reg_data_t read_data1;
	reg_data_t read_data2;
	logic      mem_read;
	logic      mem_write;
	logic      reg_write;
	reg_addr_t reg_addr;
	logic      out_credit;
	logic      hold_credits;   // Downstream refuses to return credits
	logic [31:0] lfsr;
	int        up_credits;
	int        sent;
	int        returned;
	int        owed;            // Ops seen whose credit is not yet returned
	int        tb_errors;
	int        cycles;
	int        err_count;
	int        op_count;
	int        pending;

	decode_front UUT (
		.pclk (clk), .rst_n (rst_n),
		.inst_valid (inst_valid), .inst (inst), .inst_credit (inst_credit),
		.wb_valid (wb_valid), .wb_addr (wb_addr), .wb_data (wb_data),
		.op_valid (op_valid), .read_addr1 (read_addr1), .read_addr2 (read_addr2),
		.read_data1 (read_data1), .read_data2 (read_data2), .mem_read (mem_read),
		.mem_write (mem_write), .reg_write (reg_write), .reg_addr (reg_addr),
		.out_credit (out_credit)
	);

	decode_checker checker_inst (
		.clk (clk), .rst_n (rst_n), .inst_valid (inst_valid), .inst (inst),
		.wb_valid (wb_valid), .wb_addr (wb_addr), .wb_data (wb_data),
		.op_valid (op_valid), .read_addr1 (read_addr1), .read_addr2 (read_addr2),
		.read_data1 (read_data1), .read_data2 (read_data2), .mem_read (mem_read),
		.mem_write (mem_write), .reg_write (reg_write), .reg_addr (reg_addr),
		.err_count (err_count), .op_count (op_count), .pending (pending)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[14:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// One encoding per instruction kind, free fields from f
	function automatic inst_t encode(input int kind, input logic [15:0] f);
		case (kind)
			0:  return {OP_ADDIU, f[10:0]};
			1:  return {OP_ADDIU3, f[10:5], 1'b0, f[3:0]};
			2:  return {OP_SPEC, 3'b011, f[7:0]};
			3:  return {OP_SPEC, 3'b000, f[7:0]};
			4:  return {OP_SPEC, 3'b100, f[7:5], 5'b00000};
			5:  return {OP_ALU3, f[10:2], 2'b01};
			6:  return {OP_ALU3, f[10:2], 2'b11};
			7:  return {OP_RR, f[10:5], 5'b01100};
			8:  return {OP_RR, f[10:8], 8'h00};
			9:  return {OP_RR, f[10:5], 5'b01010};
			10: return {OP_RR, f[10:8], 8'h40};
			11: return {OP_RR, f[10:5], 5'b01101};
			12: return {OP_RR, f[10:8], 8'hc0};
			13: return {OP_RR, 11'b00000100000};
			14: return {OP_RR, f[10:5], 5'b00111};
			15: return {OP_B, f[10:0]};
			16: return {OP_BEQZ, f[10:0]};
			17: return {OP_BNEZ, f[10:0]};
			18: return {OP_LI, f[10:0]};
			19: return {OP_LW, f[10:0]};
			20: return {OP_LW_SP, f[10:0]};
			21: return {OP_IH, f[10:8], 8'h00};
			22: return {OP_IH, f[10:8], 8'h01};
			23: return {OP_NOP, 11'd0};
			24: return {OP_SHIFT, f[10:2], 2'b00};
			25: return {OP_SHIFT, f[10:2], 2'b11};
			26: return {OP_SHIFT, f[10:2], 2'b10};
			27: return {OP_SW, f[10:0]};
			28: return {OP_SW_SP, f[10:0]};
			default: return {OP_MOVE, f[10:5], 5'b00000};
		endcase
	endfunction

	task automatic send(input inst_t w);
		while (up_credits == 0) begin
			@(posedge clk);
			#1;
		end
		inst_valid = 1'b1;
		inst       = w;
		up_credits--;
		sent++;
		@(posedge clk);
		#1;
		inst_valid = 1'b0;
	endtask

	task automatic drain();
		while (pending != 0 || owed != 0) begin
			@(posedge clk);
			#1;
		end
		repeat (4) @(posedge clk);
		#1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Credit bookkeeping on both sides
	////////////////////////////////////////////////////////////////////////////
	always @(negedge clk) begin
		if (rst_n && inst_credit) begin
			up_credits++;
			returned++;
			if (up_credits > QUEUE_DEPTH) begin
				tb_errors++;
				$display("[ERROR] %0t upstream holds %0d credits", $time, up_credits);
			end
		end
		if (rst_n && op_valid) owed++;
	end

	always @(posedge clk) begin
		logic [15:0] b;
		#1;
		if (rst_n && !hold_credits && owed > 0) begin
			take_bits(1, b);
			out_credit = b[0]; // Random gaps
			if (b[0]) owed--;
		end else begin
			out_credit = 1'b0;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Test FAILED");
			$finish;
		end
	end

	initial begin
		logic [15:0] f;
		logic [15:0] s;
		int          base;
		clk          = 1'b0;
		rst_n        = 1'b0;
		inst_valid   = 1'b0;
		inst         = '0;
		wb_valid     = 1'b0;
		wb_addr      = '0;
		wb_data      = '0;
		out_credit   = 1'b0;
		hold_credits = 1'b0;
		lfsr         = SEED;
		up_credits   = QUEUE_DEPTH;
		sent         = 0;
		returned     = 0;
		owed         = 0;
		tb_errors    = 0;
		cycles       = 0;
		repeat (4) @(posedge clk);
		#1 rst_n = 1'b1;

		// Idle after reset
		repeat (10) begin
			@(negedge clk);
			if (op_valid || inst_credit) begin
				tb_errors++;
				$display("[ERROR] %0t output active with no instruction sent", $time);
			end
		end
		@(posedge clk);
		#1;

		for (int r = 0; r < NUM_REGS; r++) begin
			take_bits(16, f);
			wb_valid = 1'b1;
			wb_addr  = reg_addr_t'(r);
			wb_data  = f;
			@(posedge clk);
			#1;
		end
		wb_valid = 1'b0;
		repeat (2) @(posedge clk);
		#1;

		for (int k = 0; k < 30; k++) begin
			take_bits(16, f);
			send(encode(k, f));
		end
		send(16'hffff);                                     // Unused majors
		send(16'h0000);
		send({OP_SPEC, 3'b111, 8'h5a});
		send({OP_RR, 3'b011, 3'b010, 5'b11111});
		send({OP_SHIFT, 3'b001, 3'b010, 3'b000, 2'b01});
		drain();

		// Back-pressure: only OUT_CREDITS ops may leave
		hold_credits = 1'b1;
		base = op_count;
		for (int k = 0; k < 6; k++) begin
			take_bits(16, f);
			send(encode(k * 5, f));
		end
		repeat (30) @(posedge clk);
		#1;
		if (op_count - base != OUT_CREDITS) begin
			tb_errors++;
			$display("[ERROR] %0t %0d ops sent without credit return, expected %0d",
				$time, op_count - base, OUT_CREDITS);
		end
		hold_credits = 1'b0;
		drain();

		for (int n = 0; n < 300; n++) begin
			take_bits(5, s);
			take_bits(16, f);
			send(encode(int'(s[4:0]) % 30, f));
		end
		drain();

		if (returned != sent || up_credits != QUEUE_DEPTH) begin
			tb_errors++;
			$display("[ERROR] %0t %0d instructions sent but %0d credits returned",
				$time, sent, returned);
		end
		if (op_count != sent) begin
			tb_errors++;
			$display("[ERROR] %0t %0d ops seen for %0d instructions", $time, op_count, sent);
		end
		$display("Ops checked %0d, checker errors %0d, testbench errors %0d",
			op_count, err_count, tb_errors);
		if (err_count + tb_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/inst_queue.sv
hw/inst_decoder.sv
hw/operand_fetch.sv
hw/decode_front.sv
testbench/decode_checker.sv
testbench/tb_decode_front.sv
